/* common/monitor_pkg.sv */
package monitor_pkg;

    // AXI ID width, one table entry per ID
    localparam int id_width = 4;
    localparam int max_transactions = 2 ** id_width;

    // Write lifecycle of one table entry
    typedef enum logic [2:0] {
        trans_idle,
        trans_addr_phase,
        trans_data_phase,
        trans_resp_phase,
        trans_complete,
        trans_error
    } trans_state_t;

    // Table entry, all zero while idle
    typedef struct packed {
        logic         valid;
        trans_state_t state;
        logic         cmd_received;
        logic         data_started;
        logic         data_completed;
        logic         resp_received;
        logic [7:0]   beat_count;
    } bus_transaction_t;

    // Phase that ran out of ticks
    typedef enum logic [1:0] {
        evt_none,
        evt_cmd_timeout,
        evt_data_timeout,
        evt_resp_timeout
    } timeout_code_t;

    typedef enum logic [3:0] {
        pkt_completion = 4'd1,
        pkt_timeout    = 4'd2
    } pkt_type_t;

    // Timeout report, threshold of the phase that expired
    typedef struct packed {
        timeout_code_t         code;
        logic [id_width-1:0]   id;
        logic [3:0]            threshold;
        logic [17:0]           pad;
    } timeout_view_t;

    // Completion report
    typedef struct packed {
        logic [id_width-1:0]   id;
        logic [1:0]            bresp;
        logic [7:0]            beat_count;
        logic [13:0]           pad;
    } completion_view_t;

    // Lower 28 bits, decoded by pkt_type
    typedef union packed {
        timeout_view_t    tmo;
        completion_view_t comp;
    } pkt_body_u;

    typedef struct packed {
        pkt_type_t pkt_type;
        pkt_body_u body;
    } monitor_packet_t;

endpackage

/* common/monitor_event_if.sv */
`timescale 1ns/10ps

interface monitor_event_if;

    // Write side
    logic                          push;
    monitor_pkg::monitor_packet_t  wdata;
    logic                          full;

    // Read side
    logic                          pop;
    monitor_pkg::monitor_packet_t  rdata;
    logic                          empty;

    modport writer (output push, output wdata, input full);

    modport buffer (
        input  push,
        input  wdata,
        output full,
        input  pop,
        output rdata,
        output empty
    );

    modport reader (output pop, input rdata, input empty);

endinterface

/* axi_trans_tracker/axi_trans_tracker.sv */
`timescale 1ns/10ps

module axi_trans_tracker #(
    parameter int max_transactions = 16
) (
    input  logic                                  aclk,
    input  logic                                  arst_n,
    input  logic                                  awvalid,
    input  logic                                  awready,
    input  logic [monitor_pkg::id_width-1:0]      awid,
    input  logic [7:0]                            awlen,
    input  logic                                  wvalid,
    input  logic                                  wready,
    input  logic                                  wlast,
    input  logic                                  bvalid,
    input  logic                                  bready,
    input  logic [monitor_pkg::id_width-1:0]      bid,
    input  logic [1:0]                            bresp,
    input  logic [max_transactions-1:0]           timeout_detected,
    output monitor_pkg::bus_transaction_t         trans_table [max_transactions],
    output logic                                  comp_valid,
    output monitor_pkg::monitor_packet_t          comp_packet
);

    localparam int id_w = monitor_pkg::id_width;

    // Burst length per ID, from AW
    logic [7:0]      exp_len [max_transactions];

    // IDs in AW acceptance order, waiting for W data
    logic [id_w-1:0] w_queue [max_transactions];
    logic [id_w-1:0] q_wr_ptr;
    logic [id_w-1:0] q_rd_ptr;
    logic [id_w:0]   q_count;
    logic [id_w-1:0] head_id;
    logic            head_live;
    logic            aw_accept;
    logic            q_push;
    logic            q_pop;
    logic            w_hs;
    logic            b_hs;

    assign w_hs    = wvalid && wready;
    assign b_hs    = bvalid && bready;
    assign head_id = w_queue[q_rd_ptr];

    // AW handshake for an idle ID or one still waiting in addr phase
    assign aw_accept = awvalid && awready &&
        (trans_table[awid].state == monitor_pkg::trans_idle ||
         (trans_table[awid].state == monitor_pkg::trans_addr_phase &&
          !trans_table[awid].cmd_received));
    assign q_push = aw_accept && (q_count != (id_w+1)'(max_transactions));

    // Head still owns the W stream, otherwise it was retired
    always_comb begin
        head_live = 1'b0;
        if (q_count != '0) begin
            head_live = (trans_table[head_id].state == monitor_pkg::trans_addr_phase &&
                         trans_table[head_id].cmd_received) ||
                        trans_table[head_id].state == monitor_pkg::trans_data_phase;
        end
    end

    // Stale heads are skipped without taking a beat
    assign q_pop = (q_count != '0) && (!head_live || (w_hs && wlast));

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int idx = 0; idx < max_transactions; idx++) begin
                trans_table[idx] <= '0;
            end
            comp_valid <= 1'b0;
            q_wr_ptr   <= '0;
            q_rd_ptr   <= '0;
            q_count    <= '0;
        end else begin
            comp_valid <= 1'b0;

            // Finished or failed entries go back to idle
            for (int idx = 0; idx < max_transactions; idx++) begin
                if (trans_table[idx].state == monitor_pkg::trans_complete ||
                    trans_table[idx].state == monitor_pkg::trans_error) begin
                    trans_table[idx] <= '0;
                end
            end

            // First sight of awvalid opens the entry
            if (awvalid && trans_table[awid].state == monitor_pkg::trans_idle) begin
                trans_table[awid].valid        <= 1'b1;
                trans_table[awid].state        <= monitor_pkg::trans_addr_phase;
                trans_table[awid].cmd_received <= awready;
            end else if (aw_accept) begin
                trans_table[awid].cmd_received <= 1'b1;
            end

            // W beat for the oldest command lacking data
            if (head_live && w_hs) begin
                trans_table[head_id].data_started <= 1'b1;
                trans_table[head_id].beat_count   <= trans_table[head_id].beat_count + 8'd1;
                if (!wlast) begin
                    trans_table[head_id].state <= monitor_pkg::trans_data_phase;
                end else if (trans_table[head_id].beat_count == exp_len[head_id]) begin
                    trans_table[head_id].data_completed <= 1'b1;
                    trans_table[head_id].state          <= monitor_pkg::trans_resp_phase;
                end else begin
                    // wlast off the awlen count, burst is dropped
                    trans_table[head_id].state <= monitor_pkg::trans_error;
                end
            end

            if (b_hs && trans_table[bid].state == monitor_pkg::trans_resp_phase) begin
                trans_table[bid].resp_received <= 1'b1;
                trans_table[bid].state         <= monitor_pkg::trans_complete;
                comp_valid                     <= 1'b1;
            end

            // Timeout wins over any channel update this cycle
            for (int idx = 0; idx < max_transactions; idx++) begin
                if (timeout_detected[idx] &&
                    (trans_table[idx].state == monitor_pkg::trans_addr_phase ||
                     trans_table[idx].state == monitor_pkg::trans_data_phase ||
                     trans_table[idx].state == monitor_pkg::trans_resp_phase)) begin
                    trans_table[idx].state <= monitor_pkg::trans_error;
                end
            end

            if (q_push) begin
                q_wr_ptr <= q_wr_ptr + 1'b1;
            end
            if (q_pop) begin
                q_rd_ptr <= q_rd_ptr + 1'b1;
            end
            q_count <= q_count + (id_w+1)'(q_push) - (id_w+1)'(q_pop);
        end
    end

    always_ff @(posedge aclk) begin
        if (q_push) begin
            w_queue[q_wr_ptr] <= awid;
        end
        if (aw_accept) begin
            exp_len[awid] <= awlen;
        end
        // Completion view, qualified by comp_valid
        if (b_hs) begin
            comp_packet                      <= '0;
            comp_packet.pkt_type             <= monitor_pkg::pkt_completion;
            comp_packet.body.comp.id         <= bid;
            comp_packet.body.comp.bresp      <= bresp;
            comp_packet.body.comp.beat_count <= trans_table[bid].beat_count;
        end
    end

endmodule

/* axi_monitor_timeout/axi_monitor_timeout.sv */
`timescale 1ns/10ps

module axi_monitor_timeout #(
    parameter int max_transactions = 16
) (
    input  logic                           aclk,
    input  logic                           arst_n,
    input  monitor_pkg::bus_transaction_t  trans_table [max_transactions],
    input  logic                           timer_tick,
    input  logic [3:0]                     cfg_addr_cnt,
    input  logic [3:0]                     cfg_data_cnt,
    input  logic [3:0]                     cfg_resp_cnt,
    output logic [max_transactions-1:0]    timeout_detected,
    output monitor_pkg::timeout_code_t     timeout_code [max_transactions]
);

    // Active phase of each entry, coded as its timeout event
    monitor_pkg::timeout_code_t phase      [max_transactions];
    monitor_pkg::timeout_code_t last_phase [max_transactions];
    logic [3:0]                 thresh     [max_transactions];
    logic [3:0]                 tick_cnt   [max_transactions];

    always_comb begin
        for (int idx = 0; idx < max_transactions; idx++) begin
            phase[idx]  = monitor_pkg::evt_none;
            thresh[idx] = '0;
            if (trans_table[idx].valid) begin
                case (trans_table[idx].state)
                    // Waiting for awready
                    monitor_pkg::trans_addr_phase: begin
                        if (!trans_table[idx].cmd_received) begin
                            phase[idx]  = monitor_pkg::evt_cmd_timeout;
                            thresh[idx] = cfg_addr_cnt;
                        end
                    end
                    // Burst started, wlast not seen
                    monitor_pkg::trans_data_phase: begin
                        if (!trans_table[idx].data_completed) begin
                            phase[idx]  = monitor_pkg::evt_data_timeout;
                            thresh[idx] = cfg_data_cnt;
                        end
                    end
                    monitor_pkg::trans_resp_phase: begin
                        if (!trans_table[idx].resp_received) begin
                            phase[idx]  = monitor_pkg::evt_resp_timeout;
                            thresh[idx] = cfg_resp_cnt;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            timeout_detected <= '0;
            for (int idx = 0; idx < max_transactions; idx++) begin
                tick_cnt[idx]     <= '0;
                last_phase[idx]   <= monitor_pkg::evt_none;
                timeout_code[idx] <= monitor_pkg::evt_none;
            end
        end else begin
            for (int idx = 0; idx < max_transactions; idx++) begin
                last_phase[idx] <= phase[idx];
                // Fresh count on every phase change
                if (phase[idx] != last_phase[idx]) begin
                    tick_cnt[idx] <= '0;
                end else if (timer_tick && phase[idx] != monitor_pkg::evt_none &&
                             !timeout_detected[idx]) begin
                    if (tick_cnt[idx] >= thresh[idx]) begin
                        timeout_detected[idx] <= 1'b1;
                        timeout_code[idx]     <= phase[idx];
                    end else begin
                        tick_cnt[idx] <= tick_cnt[idx] + 4'd1;
                    end
                end
                // Sticky until the tracker retires the entry
                if (trans_table[idx].state == monitor_pkg::trans_complete ||
                    trans_table[idx].state == monitor_pkg::trans_error ||
                    trans_table[idx].state == monitor_pkg::trans_idle) begin
                    timeout_detected[idx] <= 1'b0;
                end
            end
        end
    end

endmodule

/* rtl/axi_monitor_event_gen.sv */
`timescale 1ns/10ps

module axi_monitor_event_gen (
    input  logic                                      aclk,
    input  logic                                      arst_n,
    input  logic [monitor_pkg::max_transactions-1:0]  timeout_detected,
    input  monitor_pkg::timeout_code_t                timeout_code [monitor_pkg::max_transactions],
    input  logic [3:0]                                cfg_addr_cnt,
    input  logic [3:0]                                cfg_data_cnt,
    input  logic [3:0]                                cfg_resp_cnt,
    input  logic                                      cfg_timeout_enable,
    input  logic                                      comp_valid,
    input  monitor_pkg::monitor_packet_t              comp_packet,
    monitor_event_if.writer                           evt,
    output logic [7:0]                                drop_count
);

    localparam int n    = monitor_pkg::max_transactions;
    localparam int id_w = monitor_pkg::id_width;

    logic [n-1:0]    det_q;
    logic [n-1:0]    pending;
    logic [id_w-1:0] sel_id;
    logic [3:0]      sel_thresh;
    logic            tmo_push;

    // Lowest pending index wins
    always_comb begin
        sel_id = '0;
        for (int idx = n - 1; idx >= 0; idx--) begin
            if (pending[idx]) begin
                sel_id = id_w'(idx);
            end
        end
        case (timeout_code[sel_id])
            monitor_pkg::evt_cmd_timeout:  sel_thresh = cfg_addr_cnt;
            monitor_pkg::evt_data_timeout: sel_thresh = cfg_data_cnt;
            monitor_pkg::evt_resp_timeout: sel_thresh = cfg_resp_cnt;
            default:                       sel_thresh = '0;
        endcase
    end

    // Completion first, timeouts wait for room
    assign tmo_push = (|pending) && !comp_valid && !evt.full;
    assign evt.push = (comp_valid && !evt.full) || tmo_push;

    always_comb begin
        if (comp_valid) begin
            evt.wdata = comp_packet;
        end else begin
            evt.wdata                     = '0;
            evt.wdata.pkt_type            = monitor_pkg::pkt_timeout;
            evt.wdata.body.tmo.code       = timeout_code[sel_id];
            evt.wdata.body.tmo.id         = sel_id;
            evt.wdata.body.tmo.threshold  = sel_thresh;
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            det_q      <= '0;
            pending    <= '0;
            drop_count <= '0;
        end else begin
            det_q <= timeout_detected;
            if (tmo_push) begin
                pending[sel_id] <= 1'b0;
            end
            // New timeouts only while reporting is on
            for (int idx = 0; idx < n; idx++) begin
                if (timeout_detected[idx] && !det_q[idx] && cfg_timeout_enable) begin
                    pending[idx] <= 1'b1;
                end
            end
            // Completion lost on a full buffer
            if (comp_valid && evt.full && drop_count != 8'hff) begin
                drop_count <= drop_count + 8'd1;
            end
        end
    end

endmodule

/* rtl/monitor_event_fifo.sv */
`timescale 1ns/10ps

module monitor_event_fifo #(
    parameter int fifo_depth = 4
) (
    input  logic               aclk,
    input  logic               arst_n,
    monitor_event_if.buffer    evt
);

    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w = $clog2(fifo_depth + 1);

    monitor_pkg::monitor_packet_t mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign evt.full  = (count == cnt_w'(fifo_depth));
    assign evt.empty = (count == '0);
    assign evt.rdata = mem[rd_ptr];

    // Refused when full, ignored when empty
    assign do_push = evt.push && !evt.full;
    assign do_pop  = evt.pop && !evt.empty;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap at depth, not at a power of two
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
        end
    end

    always_ff @(posedge aclk) begin
        if (do_push) begin
            mem[wr_ptr] <= evt.wdata;
        end
    end

endmodule

/* rtl/monitor_reporter.sv */
`timescale 1ns/10ps

module monitor_reporter (
    input  logic                          aclk,
    input  logic                          arst_n,
    monitor_event_if.reader               evt,
    output logic                          pkt_valid,
    output monitor_pkg::monitor_packet_t  pkt_data,
    output logic [7:0]                    timeout_count,
    output logic [7:0]                    completion_count
);

    // No back-pressure, drain every cycle
    assign evt.pop = !evt.empty;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            pkt_valid        <= 1'b0;
            timeout_count    <= '0;
            completion_count <= '0;
        end else begin
            pkt_valid <= evt.pop;
            if (evt.pop) begin
                // Saturating per-type counters
                case (evt.rdata.pkt_type)
                    monitor_pkg::pkt_timeout: begin
                        if (timeout_count != 8'hff) begin
                            timeout_count <= timeout_count + 8'd1;
                        end
                    end
                    monitor_pkg::pkt_completion: begin
                        if (completion_count != 8'hff) begin
                            completion_count <= completion_count + 8'd1;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (evt.pop) begin
            pkt_data <= evt.rdata;
        end
    end

endmodule

/* rtl/axi_write_monitor.sv */
`timescale 1ns/10ps

module axi_write_monitor #(
    parameter int event_fifo_depth = 4
) (
    input  logic                              aclk,
    input  logic                              arst_n,
    input  logic                              awvalid,
    input  logic                              awready,
    input  logic [monitor_pkg::id_width-1:0]  awid,
    input  logic [7:0]                        awlen,
    input  logic                              wvalid,
    input  logic                              wready,
    input  logic                              wlast,
    input  logic                              bvalid,
    input  logic                              bready,
    input  logic [monitor_pkg::id_width-1:0]  bid,
    input  logic [1:0]                        bresp,
    input  logic                              timer_tick,
    input  logic [3:0]                        cfg_addr_cnt,
    input  logic [3:0]                        cfg_data_cnt,
    input  logic [3:0]                        cfg_resp_cnt,
    input  logic                              cfg_timeout_enable,
    output logic                              pkt_valid,
    output logic [31:0]                       pkt_data,
    output logic [7:0]                        timeout_count,
    output logic [7:0]                        completion_count,
    output logic [7:0]                        drop_count
);

    localparam int n = monitor_pkg::max_transactions;

    monitor_pkg::bus_transaction_t trans_table [n];
    monitor_pkg::timeout_code_t    timeout_code [n];
    logic [n-1:0]                  timeout_detected;
    logic                          comp_valid;
    monitor_pkg::monitor_packet_t  comp_packet;

    // Event path, generator to FIFO to reporter
    monitor_event_if evt ();

    axi_trans_tracker #(
        .max_transactions (n)
    ) u_tracker (
        .aclk, .arst_n,
        .awvalid, .awready, .awid, .awlen,
        .wvalid, .wready, .wlast,
        .bvalid, .bready, .bid, .bresp,
        .timeout_detected, .trans_table,
        .comp_valid, .comp_packet
    );

    axi_monitor_timeout #(
        .max_transactions (n)
    ) u_timeout (
        .aclk, .arst_n, .trans_table, .timer_tick,
        .cfg_addr_cnt, .cfg_data_cnt, .cfg_resp_cnt,
        .timeout_detected, .timeout_code
    );

    axi_monitor_event_gen u_event_gen (
        .aclk, .arst_n, .timeout_detected, .timeout_code,
        .cfg_addr_cnt, .cfg_data_cnt, .cfg_resp_cnt, .cfg_timeout_enable,
        .comp_valid, .comp_packet,
        .evt        (evt.writer),
        .drop_count
    );

    monitor_event_fifo #(
        .fifo_depth (event_fifo_depth)
    ) u_fifo (
        .aclk, .arst_n,
        .evt        (evt.buffer)
    );

    monitor_reporter u_reporter (
        .aclk, .arst_n,
        .evt        (evt.reader),
        .pkt_valid, .pkt_data,
        .timeout_count, .completion_count
    );

endmodule

/* testbench/tb_axi_write_monitor.sv */
`timescale 1ns/10ps

module tb_axi_write_monitor;

    localparam int fifo_depth  = 4;
    localparam int cycle_limit = 4000;
    localparam logic [3:0] addr_thr = 4'd3;
    localparam logic [3:0] data_thr = 4'd4;
    localparam logic [3:0] resp_thr = 4'd5;

    logic        aclk;
    logic        arst_n;
    logic        awvalid;
    logic        awready;
    logic [3:0]  awid;
    logic [7:0]  awlen;
    logic        wvalid;
    logic        wready;
    logic        wlast;
    logic        bvalid;
    logic        bready;
    logic [3:0]  bid;
    logic [1:0]  bresp;
    logic        timer_tick;
    logic [3:0]  cfg_addr_cnt;
    logic [3:0]  cfg_data_cnt;
    logic [3:0]  cfg_resp_cnt;
    logic        cfg_timeout_enable;
    logic        pkt_valid;
    logic [31:0] pkt_data;
    logic [7:0]  timeout_count;
    logic [7:0]  completion_count;
    logic [7:0]  drop_count;

    // Reference model state
    logic [31:0] exp_q [$];
    int          errors;
    int          n_comp;
    int          n_tmo;
    int          model_drops;
    int          occ;
    logic        b_prev;
    logic [31:0] rng;
    int          cycle_cnt;

    axi_write_monitor #(
        .event_fifo_depth (fifo_depth)
    ) dut0 (
        .aclk, .arst_n,
        .awvalid, .awready, .awid, .awlen,
        .wvalid, .wready, .wlast,
        .bvalid, .bready, .bid, .bresp,
        .timer_tick, .cfg_addr_cnt, .cfg_data_cnt, .cfg_resp_cnt, .cfg_timeout_enable,
        .pkt_valid, .pkt_data, .timeout_count, .completion_count, .drop_count
    );

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Packet words with the type in bits 31..28
    function automatic logic [31:0] comp_word(logic [3:0] id, logic [1:0] resp, logic [7:0] beats);
        return {4'd1, id, resp, beats, 14'd0};
    endfunction

    function automatic logic [31:0] tmo_word(logic [1:0] code, logic [3:0] id, logic [3:0] thr);
        return {4'd2, code, id, thr, 18'd0};
    endfunction

    task automatic step_cycle();
        @(posedge aclk);
        #1;
    endtask

    task automatic send_aw(logic [3:0] id, logic [7:0] len, int stall);
        awvalid = 1'b1;
        awid    = id;
        awlen   = len;
        awready = 1'b0;
        repeat (stall) step_cycle();
        awready = 1'b1;
        step_cycle();
        awvalid = 1'b0;
        awready = 1'b0;
    endtask

    task automatic send_w(logic [7:0] len);
        for (int b = 0; b <= len; b++) begin
            wvalid = 1'b1;
            wready = 1'b1;
            wlast  = (b == len);
            step_cycle();
        end
        wvalid = 1'b0;
        wready = 1'b0;
        wlast  = 1'b0;
    endtask

    task automatic send_b(logic [3:0] id, logic [1:0] resp, logic [7:0] len);
        bvalid = 1'b1;
        bready = 1'b1;
        bid    = id;
        bresp  = resp;
        exp_q.push_back(comp_word(id, resp, len + 8'd1));
        n_comp++;
        step_cycle();
        bvalid = 1'b0;
        bready = 1'b0;
    endtask

    task automatic write_txn(logic [3:0] id, logic [7:0] len, logic [1:0] resp, int stall);
        send_aw(id, len, stall);
        send_w(len);
        send_b(id, resp, len);
    endtask

    task automatic pulse_ticks(int count);
        repeat (count) begin
            timer_tick = 1'b1;
            step_cycle();
            timer_tick = 1'b0;
            step_cycle();
        end
    endtask

    // Last tick of a stalled phase with its expected timeout
    task automatic final_tick(logic [1:0] code, logic [3:0] id, logic [3:0] thr);
        // An early report comes out during these idle cycles
        repeat (4) step_cycle();
        exp_q.push_back(tmo_word(code, id, thr));
        n_tmo++;
        timer_tick = 1'b1;
        step_cycle();
        timer_tick = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 200) begin
            step_cycle();
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("Expected packet never came out at %0t, %0d left", $time, exp_q.size());
            exp_q.delete();
        end
        repeat (4) step_cycle();
    endtask

    // Packet check against the head of the expected queue
    always @(negedge aclk) begin
        if (arst_n && pkt_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected packet %h came out at %0t", pkt_data, $time);
            end else begin
                assert (pkt_data === exp_q[0])
                else begin
                    errors++;
                    $display("CHECK FAILED at %0t: packet %h, expected %h",
                             $time, pkt_data, exp_q[0]);
                end
                void'(exp_q.pop_front());
            end
        end
    end

    // Buffer occupancy from completions pushed one cycle after B
    always @(posedge aclk) begin
        if (!arst_n) begin
            occ    = 0;
            b_prev = 1'b0;
        end else begin
            if (b_prev && occ == fifo_depth) begin
                model_drops++;
                occ = (occ != 0) ? occ - 1 : occ;
            end else begin
                occ = occ + (b_prev ? 1 : 0) - ((occ != 0) ? 1 : 0);
            end
            b_prev = bvalid && bready;
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < cycle_limit) begin
            @(posedge aclk);
            cycle_cnt++;
        end
        $display("Run stopped after %0d cycles without finishing", cycle_limit);
        $display("Test failures found");
        $finish;
    end

    initial begin
        logic [3:0] id;
        logic [7:0] len;
        logic [1:0] resp;
        errors = 0;
        n_comp = 0;
        n_tmo = 0;
        model_drops = 0;
        rng = 32'h346a;
        arst_n = 1'b0;
        awvalid = 1'b0;
        awready = 1'b0;
        awid = '0;
        awlen = '0;
        wvalid = 1'b0;
        wready = 1'b0;
        wlast = 1'b0;
        bvalid = 1'b0;
        bready = 1'b0;
        bid = '0;
        bresp = '0;
        timer_tick = 1'b0;
        cfg_addr_cnt = addr_thr;
        cfg_data_cnt = data_thr;
        cfg_resp_cnt = resp_thr;
        cfg_timeout_enable = 1'b1;
        repeat (3) @(posedge aclk);
        #1;
        arst_n = 1'b1;
        step_cycle();

        // Plain completion
        write_txn(4'd2, 8'd3, 2'd0, 1);
        wait_drain();

        // Address phase stall
        awvalid = 1'b1;
        awready = 1'b0;
        awid    = 4'd5;
        awlen   = 8'd2;
        repeat (2) step_cycle();
        pulse_ticks(addr_thr);
        final_tick(2'd1, 4'd5, addr_thr);
        awvalid = 1'b0;
        wait_drain();

        // Same ID reused after its timeout
        write_txn(4'd5, 8'd2, 2'd1, 0);
        wait_drain();

        // Data phase stall after one beat
        send_aw(4'd6, 8'd3, 0);
        wvalid = 1'b1;
        wready = 1'b1;
        step_cycle();
        wvalid = 1'b0;
        wready = 1'b0;
        step_cycle();
        pulse_ticks(data_thr);
        final_tick(2'd2, 4'd6, data_thr);
        wait_drain();

        // Response never arrives
        send_aw(4'd7, 8'd1, 0);
        send_w(8'd1);
        step_cycle();
        pulse_ticks(resp_thr);
        final_tick(2'd3, 4'd7, resp_thr);
        wait_drain();

        // Stall with reporting off stays silent
        cfg_timeout_enable = 1'b0;
        awvalid = 1'b1;
        awid    = 4'd8;
        repeat (2) step_cycle();
        pulse_ticks(addr_thr + 2);
        awvalid = 1'b0;
        repeat (10) step_cycle();
        cfg_timeout_enable = 1'b1;
        wait_drain();

        // Burst of completions back to back
        for (int i = 1; i <= 6; i++) begin
            send_aw(4'(i), 8'(i % 3), 0);
            send_w(8'(i % 3));
        end
        bvalid = 1'b1;
        bready = 1'b1;
        for (int i = 1; i <= 6; i++) begin
            bid   = 4'(i);
            bresp = 2'(i);
            exp_q.push_back(comp_word(4'(i), 2'(i), 8'(i % 3) + 8'd1));
            n_comp++;
            step_cycle();
        end
        bvalid = 1'b0;
        bready = 1'b0;
        wait_drain();

        // Random traffic with stalls below the thresholds
        for (int i = 0; i < 30; i++) begin
            id   = 4'(next_rand());
            len  = 8'(next_rand() % 4);
            resp = 2'(next_rand());
            // Entry needs a cycle after B to return to idle
            repeat (1 + next_rand() % 4) step_cycle();
            write_txn(id, len, resp, int'(next_rand() % 3));
        end
        wait_drain();

        assert (completion_count == 8'(n_comp))
        else begin
            errors++;
            $display("CHECK FAILED at %0t: completion_count %0d, expected %0d",
                     $time, completion_count, n_comp);
        end
        assert (timeout_count == 8'(n_tmo))
        else begin
            errors++;
            $display("CHECK FAILED at %0t: timeout_count %0d, expected %0d",
                     $time, timeout_count, n_tmo);
        end
        assert (drop_count == 8'(model_drops))
        else begin
            errors++;
            $display("CHECK FAILED at %0t: drop_count %0d, expected %0d",
                     $time, drop_count, model_drops);
        end

        $display("Errors: %0d, completions %0d, timeouts %0d", errors, n_comp, n_tmo);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* sim.f */
common/monitor_pkg.sv
common/monitor_event_if.sv
axi_trans_tracker/axi_trans_tracker.sv
axi_monitor_timeout/axi_monitor_timeout.sv
rtl/axi_monitor_event_gen.sv
rtl/monitor_event_fifo.sv
rtl/monitor_reporter.sv
rtl/axi_write_monitor.sv
testbench/tb_axi_write_monitor.sv

/* Bender.yml */
package:
  name: axi_write_monitor

sources:
  - common/monitor_pkg.sv
  - common/monitor_event_if.sv
  - axi_trans_tracker/axi_trans_tracker.sv
  - axi_monitor_timeout/axi_monitor_timeout.sv
  - rtl/axi_monitor_event_gen.sv
  - rtl/monitor_event_fifo.sv
  - rtl/monitor_reporter.sv
  - rtl/axi_write_monitor.sv
  - target: test
    files:
      - testbench/tb_axi_write_monitor.sv
